//--- Bender.yml
package:
  name: psx_pad_host

sources:
  - files:
      - source/psx_pkg.sv
      - source/psx_byte_if.sv
      - source/psx_poll_sequencer.sv
      - source/psx_byte_shifter.sv
      - source/psx_report_stage.sv
      - source/psx_pad_host.sv
  - target: test
    files:
      - testbench/psx_pad_model.sv
      - testbench/tb_psx_pad_host.sv

//--- psx_pad_host.f
source/psx_pkg.sv
source/psx_byte_if.sv
source/psx_poll_sequencer.sv
source/psx_byte_shifter.sv
source/psx_report_stage.sv
source/psx_pad_host.sv
testbench/psx_pad_model.sv
testbench/tb_psx_pad_host.sv

//--- source/psx_byte_if.sv
`timescale 1ns/1ps

// one byte exchange, sequencer to shifter
interface psx_byte_if;
    logic       req;
    logic [7:0] tx_byte;
    logic       last_byte; // no pad ack expected after this byte
    logic       ack;
    logic [7:0] rx_byte;
    logic       acked;

    modport master (
        output req, tx_byte, last_byte,
        input  ack, rx_byte, acked
    );

    modport slave (
        input  req, tx_byte, last_byte,
        output ack, rx_byte, acked
    );
endinterface

// finished poll frame, sequencer to report stage
interface psx_frame_if;
    import psx_pkg::*;

    logic       valid; // one cycle pulse
    psx_frame_t frame;

    modport source (output valid, frame);
    modport sink (input valid, frame);
endinterface

//--- source/psx_byte_shifter.sv
`timescale 1ns/1ps

module psx_byte_shifter #(
    parameter logic [7:0]  half_bit_cycles    = 8'd4,
    parameter logic [7:0]  byte_setup_cycles  = 8'd8,
    parameter logic [15:0] ack_timeout_cycles = 16'd64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       data,
    input  logic       pad_ack,
    output logic       psx_clk,
    output logic       cmd,
    psx_byte_if.slave  byte_s
);

    typedef enum logic [2:0] {
        sh_idle,
        sh_setup,
        sh_shift,
        sh_ack_wait,
        sh_done
    } sh_state_e;

    sh_state_e   state;
    logic [15:0] cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  rx_sr;
    logic        half_end;

    assign half_end       = (cnt == {8'd0, half_bit_cycles} - 16'd1);
    assign byte_s.rx_byte = rx_sr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= sh_idle;
            cnt          <= 16'd0;
            bit_idx      <= 3'd0;
            psx_clk      <= 1'b1;
            cmd          <= 1'b1;
            byte_s.ack   <= 1'b0;
            byte_s.acked <= 1'b0;
        end else begin
            case (state)
                sh_idle: begin
                    cnt     <= 16'd0;
                    bit_idx <= 3'd0;
                    if (byte_s.req) begin
                        state <= sh_setup;
                    end
                end
                sh_setup: begin
                    if (cnt == {8'd0, byte_setup_cycles} - 16'd1) begin
                        cnt     <= 16'd0;
                        psx_clk <= 1'b0;
                        cmd     <= byte_s.tx_byte[0]; // lsb first
                        state   <= sh_shift;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                sh_shift: begin
                    if (!half_end) begin
                        cnt <= cnt + 16'd1;
                    end else begin
                        cnt <= 16'd0;
                        if (!psx_clk) begin
                            psx_clk <= 1'b1;
                        end else if (bit_idx == 3'd7) begin
                            cmd <= 1'b1;
                            if (byte_s.last_byte) begin
                                byte_s.acked <= 1'b1;
                                byte_s.ack   <= 1'b1;
                                state        <= sh_done;
                            end else begin
                                state <= sh_ack_wait;
                            end
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            psx_clk <= 1'b0;
                            cmd     <= byte_s.tx_byte[bit_idx + 3'd1];
                        end
                    end
                end
                sh_ack_wait: begin
                    if (!pad_ack) begin
                        byte_s.acked <= 1'b1;
                        byte_s.ack   <= 1'b1;
                        state        <= sh_done;
                    end else if (cnt == ack_timeout_cycles - 16'd1) begin
                        byte_s.acked <= 1'b0; // timed out
                        byte_s.ack   <= 1'b1;
                        state        <= sh_done;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                sh_done: begin
                    if (!byte_s.req) begin
                        byte_s.ack <= 1'b0;
                        state      <= sh_idle;
                    end
                end
                default: state <= sh_idle;
            endcase
        end
    end

    // sample data as psx_clk goes high
    always_ff @(posedge clk) begin
        if (state == sh_shift && half_end && !psx_clk) begin
            rx_sr[bit_idx] <= data;
        end
    end

endmodule

//--- source/psx_pad_host.sv
`timescale 1ns/1ps

module psx_pad_host #(
    parameter logic [31:0] boot_cycles        = 32'd1000,
    parameter logic [15:0] att_gap_cycles     = 16'd20,
    parameter logic [7:0]  half_bit_cycles    = 8'd4,
    parameter logic [7:0]  byte_setup_cycles  = 8'd8,
    parameter logic [15:0] ack_timeout_cycles = 16'd64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               data,
    input  logic               pad_ack,
    input  logic               report_ack,
    output logic               psx_clk,
    output logic               cmd,
    output logic               att,
    output logic               report_req,
    output logic [15:0]        buttons,
    output psx_pkg::psx_mode_e pad_mode
);

    psx_byte_if  byte_bus ();
    psx_frame_if frame_bus ();

    psx_poll_sequencer #(
        .boot_cycles    (boot_cycles),
        .att_gap_cycles (att_gap_cycles)
    ) psx_poll_sequencer_inst (
        .clk     (clk),
        .rst     (rst),
        .att     (att),
        .byte_m  (byte_bus.master),
        .frame_o (frame_bus.source)
    );

    psx_byte_shifter #(
        .half_bit_cycles    (half_bit_cycles),
        .byte_setup_cycles  (byte_setup_cycles),
        .ack_timeout_cycles (ack_timeout_cycles)
    ) psx_byte_shifter_inst (
        .clk     (clk),
        .rst     (rst),
        .data    (data),
        .pad_ack (pad_ack),
        .psx_clk (psx_clk),
        .cmd     (cmd),
        .byte_s  (byte_bus.slave)
    );

    psx_report_stage psx_report_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .report_ack (report_ack),
        .frame_s    (frame_bus.sink),
        .report_req (report_req),
        .buttons    (buttons),
        .pad_mode   (pad_mode)
    );

endmodule

//--- source/psx_pkg.sv
package psx_pkg;

    // command bytes sent on cmd
    typedef enum logic [7:0] {
        cmd_idle  = 8'h00,
        cmd_start = 8'h01,
        cmd_poll  = 8'h42
    } psx_cmd_e;

    typedef enum logic [3:0] {
        boot_wait     = 4'h0,
        att_high      = 4'h1,
        att_low_setup = 4'h2,
        xfer_start    = 4'h3,
        xfer_poll     = 4'h4,
        xfer_id_tail  = 4'h5,
        xfer_btn_lo   = 4'h6,
        xfer_btn_hi   = 4'h7,
        att_release   = 4'h8
    } psx_seq_state_e;

    // upper nibble of the pad id
    typedef enum logic [3:0] {
        mode_digital = 4'h4,
        mode_analog  = 4'h7
    } psx_mode_e;

    // raw reply bytes of one poll, buttons still active low
    typedef struct packed {
        logic [7:0] id;
        logic [7:0] btn_lo;
        logic [7:0] btn_hi;
    } psx_frame_t;

endpackage

//--- source/psx_poll_sequencer.sv
`timescale 1ns/1ps

module psx_poll_sequencer #(
    parameter logic [31:0] boot_cycles    = 32'd1000,
    parameter logic [15:0] att_gap_cycles = 16'd20
) (
    input  logic        clk,
    input  logic        rst,
    output logic        att,
    psx_byte_if.master  byte_m,
    psx_frame_if.source frame_o
);

    import psx_pkg::*;

    psx_seq_state_e state;
    psx_seq_state_e next_xfer;
    psx_cmd_e       tx_cmd;
    logic [31:0]    wait_cnt;
    psx_frame_t     frame_q;
    logic           byte_free;
    logic           byte_done;

    assign byte_free = !byte_m.req && !byte_m.ack;
    assign byte_done = byte_m.req && byte_m.ack;

    // command byte and successor per transfer state
    always_comb begin
        tx_cmd    = cmd_idle;
        next_xfer = att_release;
        case (state)
            xfer_start: begin
                tx_cmd    = cmd_start;
                next_xfer = xfer_poll;
            end
            xfer_poll: begin
                tx_cmd    = cmd_poll;
                next_xfer = xfer_id_tail;
            end
            xfer_id_tail: next_xfer = xfer_btn_lo;
            xfer_btn_lo:  next_xfer = xfer_btn_hi;
            default: ;
        endcase
    end

    assign byte_m.tx_byte   = tx_cmd;
    assign byte_m.last_byte = (state == xfer_btn_hi); // pad gives no ack on the last byte
    assign frame_o.frame    = frame_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= boot_wait;
            wait_cnt      <= 32'd0;
            att           <= 1'b1;
            byte_m.req    <= 1'b0;
            frame_o.valid <= 1'b0;
        end else begin
            frame_o.valid <= 1'b0;
            case (state)
                boot_wait: begin
                    if (wait_cnt == boot_cycles - 32'd1) begin
                        wait_cnt <= 32'd0;
                        state    <= att_high;
                    end else begin
                        wait_cnt <= wait_cnt + 32'd1;
                    end
                end
                att_high: state <= att_low_setup;
                att_low_setup: begin
                    att   <= 1'b0;
                    state <= xfer_start;
                end
                xfer_start, xfer_poll, xfer_id_tail, xfer_btn_lo, xfer_btn_hi: begin
                    if (byte_free) begin
                        byte_m.req <= 1'b1;
                    end else if (byte_done) begin
                        byte_m.req <= 1'b0;
                        if (!byte_m.acked) begin
                            state <= att_release; // pad went quiet, drop the frame
                        end else if (state == xfer_btn_hi) begin
                            frame_o.valid <= 1'b1;
                            state         <= att_release;
                        end else begin
                            state <= next_xfer;
                        end
                    end
                end
                att_release: begin
                    att <= 1'b1;
                    if (wait_cnt + 32'd1 >= {16'd0, att_gap_cycles}) begin
                        wait_cnt <= 32'd0;
                        state    <= att_high;
                    end else begin
                        wait_cnt <= wait_cnt + 32'd1;
                    end
                end
                default: state <= boot_wait;
            endcase
        end
    end

    // reply bytes worth keeping
    always_ff @(posedge clk) begin
        if (byte_done) begin
            case (state)
                xfer_poll:   frame_q.id     <= byte_m.rx_byte;
                xfer_btn_lo: frame_q.btn_lo <= byte_m.rx_byte;
                xfer_btn_hi: frame_q.btn_hi <= byte_m.rx_byte;
                default: ;
            endcase
        end
    end

endmodule

//--- source/psx_report_stage.sv
`timescale 1ns/1ps

module psx_report_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                report_ack,
    psx_frame_if.sink           frame_s,
    output logic                report_req,
    output logic [15:0]         buttons,
    output psx_pkg::psx_mode_e  pad_mode
);

    import psx_pkg::*;

    typedef enum logic [1:0] {
        out_idle,
        out_load,
        out_req,
        out_release
    } out_state_e;

    out_state_e  out_state;
    logic        id_ok;
    logic        take;
    logic        out_free;
    logic [15:0] new_buttons;
    psx_mode_e   new_mode;
    logic        pend_valid;
    logic [15:0] pend_buttons;
    psx_mode_e   pend_mode;

    assign id_ok = (frame_s.frame.id[7:4] == mode_digital ||
                    frame_s.frame.id[7:4] == mode_analog) &&
                   (frame_s.frame.id[3:0] != 4'h0);
    assign take        = frame_s.valid && id_ok;
    assign new_buttons = ~{frame_s.frame.btn_hi, frame_s.frame.btn_lo}; // pressed high
    assign new_mode    = psx_mode_e'(frame_s.frame.id[7:4]);
    assign out_free    = (out_state == out_idle) ||
                         (out_state == out_release && !report_ack);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_state  <= out_idle;
            report_req <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            if (take && !out_free) begin
                pend_valid <= 1'b1;
            end
            case (out_state)
                out_idle: if (take) out_state <= out_load;
                out_load: begin
                    report_req <= 1'b1;
                    out_state  <= out_req;
                end
                out_req: begin
                    if (report_ack) begin
                        report_req <= 1'b0;
                        out_state  <= out_release;
                    end
                end
                out_release: begin
                    if (!report_ack) begin
                        pend_valid <= 1'b0;
                        out_state  <= (take || pend_valid) ? out_load : out_idle;
                    end
                end
                default: out_state <= out_idle;
            endcase
        end
    end

    // newest frame wins, pending or direct
    always_ff @(posedge clk) begin
        if (take && !out_free) begin
            pend_buttons <= new_buttons;
            pend_mode    <= new_mode;
        end
        if (take && out_free) begin
            buttons  <= new_buttons;
            pad_mode <= new_mode;
        end else if (out_free && pend_valid) begin
            buttons  <= pend_buttons;
            pad_mode <= pend_mode;
        end
    end

endmodule

//--- testbench/psx_pad_model.sv
`timescale 1ns/1ps

module psx_pad_model (
    input  logic       clk,
    input  logic       rst,
    input  logic       att,
    input  logic       psx_clk,
    input  logic       cmd,
    input  logic       ack_enable,
    input  logic [7:0] id,
    input  logic [7:0] btn_lo,
    input  logic [7:0] btn_hi,
    output logic       data,
    output logic       ack,
    output logic       cmd_valid, // one cycle per received byte
    output logic [7:0] cmd_byte,
    output logic [2:0] cmd_index
);

    logic       clk_q;
    logic [2:0] bit_cnt;
    logic [2:0] byte_cnt;
    logic [7:0] cmd_sr;
    logic [2:0] ack_cnt;
    logic [7:0] reply;

    // answer for the current byte of the poll
    always_comb begin
        case (byte_cnt)
            3'd0:    reply = 8'hff;
            3'd1:    reply = id;
            3'd2:    reply = 8'h5a;
            3'd3:    reply = btn_lo;
            default: reply = btn_hi;
        endcase
    end

    initial begin
        data      = 1'b1;
        ack       = 1'b1;
        cmd_valid = 1'b0;
    end

    always @(posedge clk) begin
        cmd_valid <= 1'b0;
        clk_q     <= psx_clk;
        if (rst || att) begin
            bit_cnt  <= 3'd0;
            byte_cnt <= 3'd0;
            ack_cnt  <= 3'd0;
            data     <= 1'b1;
            ack      <= 1'b1;
        end else begin
            if (ack_cnt != 3'd0) begin
                ack_cnt <= ack_cnt - 3'd1;
                ack     <= !(ack_cnt == 3'd3 || ack_cnt == 3'd2); // low for 2 cycles
            end
            if (clk_q && !psx_clk) begin
                data <= reply[bit_cnt];
            end
            if (!clk_q && psx_clk) begin
                cmd_sr[bit_cnt] <= cmd; // lsb first
                bit_cnt         <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    cmd_byte  <= {cmd, cmd_sr[6:0]};
                    cmd_index <= byte_cnt;
                    cmd_valid <= 1'b1;
                    byte_cnt  <= byte_cnt + 3'd1;
                    if (ack_enable && byte_cnt != 3'd4) begin
                        ack_cnt <= 3'd4; // short pause, then ack
                    end
                end
            end
        end
    end

endmodule

//--- testbench/tb_psx_pad_host.sv
`timescale 1ns/1ps

module tb_psx_pad_host;

    import psx_pkg::*;

    localparam int boot_len    = 40;
    localparam int cycle_limit = 30 * (5 * (3 + 32 + 22) + 60) + 100;
    localparam int report_wait = 40;

    typedef struct packed {
        logic        valid;
        psx_mode_e   mode;
        logic [15:0] buttons;
    } report_t;

    logic        clk;
    logic        rst;
    logic        report_ack;
    logic        data;
    logic        pad_ack;
    logic        psx_clk;
    logic        cmd;
    logic        att;
    logic        report_req;
    logic [15:0] buttons;
    psx_mode_e   pad_mode;
    logic        ack_enable;
    logic [7:0]  pad_id;
    logic [7:0]  pad_lo;
    logic [7:0]  pad_hi;
    logic        cmd_valid;
    logic [7:0]  cmd_byte;
    logic [2:0]  cmd_index;
    logic [7:0]  rec_id; // last completed frame
    logic [7:0]  rec_lo;
    logic [7:0]  rec_hi;
    string       current_test;
    int          test_errors;
    int          total_errors;
    int          tests_passed;
    int          tests_failed;
    int          report_count;
    int          cmd_total;
    int          cycles;
    bit          hold_ack;
    int unsigned ack_delays [64];

    psx_pad_host #(
        .boot_cycles        (32'd40),
        .att_gap_cycles     (16'd10),
        .half_bit_cycles    (8'd2),
        .byte_setup_cycles  (8'd3),
        .ack_timeout_cycles (16'd20)
    ) psx_pad_host_inst (
        .clk        (clk),
        .rst        (rst),
        .data       (data),
        .pad_ack    (pad_ack),
        .report_ack (report_ack),
        .psx_clk    (psx_clk),
        .cmd        (cmd),
        .att        (att),
        .report_req (report_req),
        .buttons    (buttons),
        .pad_mode   (pad_mode)
    );

    psx_pad_model pad_model_inst (
        .clk        (clk),
        .rst        (rst),
        .att        (att),
        .psx_clk    (psx_clk),
        .cmd        (cmd),
        .ack_enable (ack_enable),
        .id         (pad_id),
        .btn_lo     (pad_lo),
        .btn_hi     (pad_hi),
        .data       (data),
        .ack        (pad_ack),
        .cmd_valid  (cmd_valid),
        .cmd_byte   (cmd_byte),
        .cmd_index  (cmd_index)
    );

    function automatic report_t expected_report(input logic [7:0] id, input logic [7:0] lo,
                                                input logic [7:0] hi);
        report_t r;
        r.valid   = (id[7:4] == 4'h4 || id[7:4] == 4'h7) && id[3:0] != 4'h0;
        r.mode    = psx_mode_e'(id[7:4]);
        r.buttons = ~{hi, lo}; // pad buttons are active low
        return r;
    endfunction

    function automatic logic [7:0] expected_cmd(input logic [2:0] index);
        case (index)
            3'd0:    return 8'h01;
            3'd1:    return 8'h42;
            default: return 8'h00;
        endcase
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error %s %s: expected %0h, actual %0h", current_test, what, expected,
                     actual);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic require(input bit cond, input string msg);
        assert (cond) else begin
            $display("%s: %s", current_test, msg);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        test_errors  = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s passed", current_test);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", current_test, test_errors);
            tests_failed++;
        end
    endtask

    // report_mode 0 no report, 1 report expected, 2 not checked
    task automatic poll_frame(input logic [7:0] id, input logic [7:0] lo, input logic [7:0] hi,
                              input bit ack_en, input int report_mode);
        int reports_before;
        int cmds_before;
        int waited;
        while (!att) @(posedge clk); // let a running frame end
        pad_id     <= id;
        pad_lo     <= lo;
        pad_hi     <= hi;
        ack_enable <= ack_en;
        while (att) @(posedge clk);
        reports_before = report_count;
        cmds_before    = cmd_total;
        while (!att) @(posedge clk);
        if (ack_en) begin
            rec_id = id;
            rec_lo = lo;
            rec_hi = hi;
            compare_value("bytes per frame", 5, cmd_total - cmds_before);
        end else begin
            compare_value("bytes per aborted frame", 1, cmd_total - cmds_before);
        end
        if (report_mode == 0) begin
            repeat (8) @(posedge clk);
            require(report_count == reports_before, "a report followed a frame without one");
        end else if (report_mode == 1) begin
            waited = 0;
            while (report_count == reports_before && waited < report_wait) begin
                @(posedge clk);
                waited++;
            end
            require(report_count != reports_before, "no report came after a valid frame");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the tests did not complete", cycle_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // command byte and attention monitor
    initial begin
        cmd_total = 0;
        forever begin
            @(posedge clk);
            if (cmd_valid) begin
                cmd_total++;
                compare_value("command byte", expected_cmd(cmd_index), cmd_byte);
            end
            if (!rst && !psx_clk) begin
                require(!att, "psx_clk went low while att was high");
            end
        end
    end

    // consumer side, compares each report as it rises
    initial begin
        report_t exp;
        int      delay;
        report_ack   = 1'b0;
        report_count = 0;
        forever begin
            @(posedge clk);
            if (report_req && !report_ack) begin
                exp = expected_report(rec_id, rec_lo, rec_hi);
                report_count++;
                require(exp.valid, "report raised although the last frame had an invalid id");
                compare_value("buttons", exp.buttons, buttons);
                compare_value("pad_mode", exp.mode, pad_mode);
                delay = ack_delays[report_count % 64];
                repeat (delay) begin
                    @(posedge clk);
                    require(report_req, "report_req fell before report_ack rose");
                end
                while (hold_ack) begin
                    @(posedge clk);
                    require(report_req, "report_req fell before report_ack rose");
                end
                report_ack <= 1'b1;
                while (report_req) @(posedge clk);
                report_ack <= 1'b0;
            end
        end
    end

    initial begin
        int          i;
        int          reports_before;
        int          waited;
        logic [31:0] rand_word;
        void'($urandom(32'hfc339cb4));
        for (i = 0; i < 64; i++) begin
            ack_delays[i] = $urandom_range(6, 2);
        end
        rst          = 1'b1;
        hold_ack     = 1'b0;
        ack_enable   = 1'b1;
        pad_id       = 8'h41;
        pad_lo       = 8'hff;
        pad_hi       = 8'hff;
        rec_id       = 8'h00;
        rec_lo       = 8'h00;
        rec_hi       = 8'h00;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        begin_test("reset");
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        begin_test("boot_quiet");
        for (i = 0; i < boot_len; i++) begin
            require(att && psx_clk && cmd && !report_req, "pad bus not idle during boot");
            @(posedge clk);
        end
        finish_test();

        begin_test("digital_buttons");
        for (i = 0; i < 4; i++) begin
            rand_word = $urandom;
            poll_frame(8'h41, rand_word[7:0], rand_word[15:8], 1'b1, 1);
        end
        finish_test();

        begin_test("analog_mode");
        rand_word = $urandom;
        poll_frame(8'h73, rand_word[7:0], rand_word[15:8], 1'b1, 1);
        finish_test();

        begin_test("invalid_id");
        poll_frame(8'hff, 8'h00, 8'h00, 1'b1, 0);
        poll_frame(8'h40, 8'hfe, 8'hef, 1'b1, 0); // zero length nibble
        finish_test();

        begin_test("missing_ack");
        for (i = 0; i < 2; i++) begin
            rand_word = $urandom;
            poll_frame(8'h41, rand_word[7:0], rand_word[15:8], 1'b0, 0);
        end
        finish_test();

        begin_test("ack_resume");
        for (i = 0; i < 2; i++) begin
            rand_word = $urandom;
            poll_frame(8'h41, rand_word[7:0], rand_word[15:8], 1'b1, 1);
        end
        finish_test();

        begin_test("back_pressure");
        rand_word = $urandom;
        poll_frame(8'h41, rand_word[7:0], rand_word[15:8], 1'b1, 1);
        hold_ack       = 1'b1; // consumer stalls on this report
        reports_before = report_count;
        for (i = 0; i < 3; i++) begin
            rand_word = $urandom;
            poll_frame(8'h41, rand_word[7:0], rand_word[15:8], 1'b1, 2);
        end
        require(report_req, "report_req fell while report_ack was held off");
        compare_value("reports while held", reports_before, report_count);
        hold_ack = 1'b0;
        waited   = 0;
        while (report_count == reports_before && waited < report_wait) begin
            @(posedge clk);
            waited++;
        end
        require(report_count != reports_before, "pending frame was not reported after release");
        while (report_req || report_ack) @(posedge clk);
        finish_test();

        $display("tests passed %0d, tests failed %0d, errors %0d", tests_passed, tests_failed,
                 total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
